//--- common/uart_pkg.sv
package uart_pkg;

    // One serial data byte
    typedef logic [7:0] uart_byte_t;

    // Oversampling ticks per bit period
    localparam int UART_TICKS_PER_BIT = 16;

    // 50 MHz / (9600 * 16)
    localparam int UART_DEFAULT_BAUD_DIV = 326;

endpackage

//--- common/debug_pkg.sv
package debug_pkg;

    localparam int NUM_REGISTERS = 32;

    typedef logic [31:0] reg_word_t;
    typedef logic [NUM_REGISTERS*$bits(reg_word_t)-1:0] reg_bank_t; // Register 0 in the low word

    localparam int REG_BANK_BYTES = $bits(reg_bank_t) / 8;

    typedef logic [5:0]  mem_addr_t; // 64-byte data memory
    typedef logic [31:0] mem_word_t;
    typedef logic [31:0] inst_t;
    typedef logic [7:0]  inst_addr_t;

    // Host command codes
    typedef logic [7:0] cmd_t;

    localparam cmd_t CMD_DUMP_REGS  = 8'h01;
    localparam cmd_t CMD_LOAD       = 8'h07;
    localparam cmd_t CMD_CONTINUOUS = 8'h08;
    localparam cmd_t CMD_STEP_MODE  = 8'h09;
    localparam cmd_t CMD_STEP       = 8'h0A;
    localparam cmd_t CMD_READ_MEM   = 8'h0B;
    localparam cmd_t CMD_RUN        = 8'h11;

    localparam cmd_t ACK_BYTE = 8'h52; // "R"

    // What the sender puts in front of the acknowledge
    typedef logic [1:0] dump_kind_t;

    localparam dump_kind_t DUMP_REGS     = 2'd0;
    localparam dump_kind_t DUMP_MEM      = 2'd1;
    localparam dump_kind_t DUMP_ACK_ONLY = 2'd2;

endpackage

//--- uart/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen #(
    parameter int P_BAUD_DIV = uart_pkg::UART_DEFAULT_BAUD_DIV
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);

    logic [$clog2(P_BAUD_DIV)-1:0] count;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            if (int'(count) == P_BAUD_DIV - 1) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            o_tick <= (int'(count) == P_BAUD_DIV - 1);
        end
    end

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_rx,
    output logic                 o_valid,
    output uart_pkg::uart_byte_t o_data
);
    import uart_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t                               state;
    logic [1:0]                              rx_sync;
    logic [$clog2(UART_TICKS_PER_BIT)-1:0]   tick_cnt;
    logic [2:0]                              bit_cnt;
    uart_byte_t                              shift;
    logic                                    mid_tick;
    logic                                    bit_end;

    assign mid_tick = i_tick && int'(tick_cnt) == UART_TICKS_PER_BIT / 2 - 1;
    assign bit_end  = i_tick && int'(tick_cnt) == UART_TICKS_PER_BIT - 1; // Mid-bit after the start

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= RX_IDLE;
            rx_sync  <= 2'b11; // Idle line is high
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_valid  <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
            o_valid <= 1'b0;
            if (state == RX_IDLE || mid_tick && state == RX_START) begin
                tick_cnt <= '0;
            end else if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                RX_IDLE:  if (!rx_sync[1]) state <= RX_START;
                RX_START: if (mid_tick) begin
                    bit_cnt <= '0;
                    state   <= rx_sync[1] ? RX_IDLE : RX_DATA; // Glitch, not a start bit
                end
                RX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (bit_end) begin
                    state   <= RX_IDLE;
                    o_valid <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_end) begin
            shift <= {rx_sync[1], shift[7:1]}; // LSB first
        end
        if (state == RX_STOP && bit_end) begin
            o_data <= shift;
        end
    end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_start,
    input  uart_pkg::uart_byte_t i_data,
    output logic                 o_done,
    output logic                 o_tx
);
    import uart_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t                             state;
    logic [$clog2(UART_TICKS_PER_BIT)-1:0] tick_cnt;
    logic [2:0]                            bit_cnt;
    uart_byte_t                            shift;
    logic                                  bit_end;

    assign bit_end = i_tick && int'(tick_cnt) == UART_TICKS_PER_BIT - 1;
    assign o_tx    = (state == TX_START) ? 1'b0 : (state == TX_DATA) ? shift[0] : 1'b1;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (state == TX_IDLE) begin
                tick_cnt <= '0;
            end else if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1; // Wraps at the end of each bit
            end
            case (state)
                TX_IDLE:  if (i_start) state <= TX_START;
                TX_START: if (bit_end) begin
                    bit_cnt <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= TX_STOP;
                end
                TX_STOP: if (bit_end) begin
                    state  <= TX_IDLE;
                    o_done <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_start) begin
            shift <= i_data;
        end else if (state == TX_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule

//--- hw/command_fsm.sv
`timescale 1ns/1ps

module command_fsm (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_rx_valid,
    input  uart_pkg::uart_byte_t  i_rx_data,
    input  logic                  i_load_done,
    input  logic                  i_dump_done,
    output logic                  o_mode,
    output logic                  o_step_en,
    output debug_pkg::mem_addr_t  o_debug_addr,
    output logic                  o_load_start,
    output logic                  o_dump_req,
    output debug_pkg::dump_kind_t o_dump_kind
);
    import debug_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_ADDR,
        ST_LOADING,
        ST_WAIT_RUN,
        ST_DUMPING
    } state_t;

    state_t state;
    logic   saved_mode; // Mode in force before a program load
    logic   step_pulse;
    logic   addr_ready;

    // Continuous mode runs freely, step mode only on a step pulse
    assign o_step_en = !o_mode || step_pulse;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            o_mode       <= 1'b0;
            saved_mode   <= 1'b0;
            step_pulse   <= 1'b0;
            addr_ready   <= 1'b0;
            o_debug_addr <= '0;
            o_load_start <= 1'b0;
            o_dump_req   <= 1'b0;
            o_dump_kind  <= DUMP_REGS;
        end else begin
            step_pulse   <= 1'b0;
            addr_ready   <= 1'b0;
            o_load_start <= 1'b0;
            o_dump_req   <= 1'b0;
            case (state)
                ST_IDLE: if (i_rx_valid) begin
                    case (cmd_t'(i_rx_data))
                        CMD_DUMP_REGS: begin
                            o_dump_req  <= 1'b1;
                            o_dump_kind <= DUMP_REGS;
                            state       <= ST_DUMPING;
                        end
                        CMD_LOAD: begin
                            saved_mode   <= o_mode;
                            o_mode       <= 1'b0;
                            o_load_start <= 1'b1;
                            state        <= ST_LOADING;
                        end
                        CMD_READ_MEM:   state <= ST_READ_ADDR;
                        CMD_CONTINUOUS: o_mode <= 1'b0;
                        CMD_STEP_MODE:  o_mode <= 1'b1;
                        CMD_STEP:       step_pulse <= o_mode;
                        default: ; // Unknown bytes are dropped
                    endcase
                end
                ST_READ_ADDR: if (i_rx_valid) begin
                    o_debug_addr <= i_rx_data[$bits(mem_addr_t)-1:0];
                    addr_ready   <= 1'b1; // Give the memory a cycle to answer
                    state        <= ST_DUMPING;
                end
                ST_LOADING: if (i_load_done) state <= ST_WAIT_RUN;
                ST_WAIT_RUN: if (i_rx_valid && cmd_t'(i_rx_data) == CMD_RUN) begin
                    o_mode      <= saved_mode;
                    o_dump_req  <= 1'b1;
                    o_dump_kind <= DUMP_ACK_ONLY;
                    state       <= ST_DUMPING;
                end
                ST_DUMPING: begin
                    if (addr_ready) begin
                        o_dump_req  <= 1'b1;
                        o_dump_kind <= DUMP_MEM;
                    end
                    if (i_dump_done) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hw/program_loader.sv
`timescale 1ns/1ps

module program_loader (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  logic                 i_rx_valid,
    input  uart_pkg::uart_byte_t i_rx_data,
    output logic                 o_done,
    output logic                 o_inst_we,
    output debug_pkg::inst_addr_t o_write_addr,
    output debug_pkg::inst_t     o_write_data
);
    import debug_pkg::*;

    typedef enum logic [1:0] {LD_IDLE, LD_COUNT, LD_DATA} ld_state_t;

    ld_state_t  state;
    inst_addr_t count;
    inst_addr_t inst_idx;
    logic [1:0] byte_idx;
    logic [23:0] inst_buf; // Lower three bytes of the instruction

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= LD_IDLE;
            count        <= '0;
            inst_idx     <= '0;
            byte_idx     <= '0;
            o_done       <= 1'b0;
            o_inst_we    <= 1'b0;
            o_write_addr <= '0;
        end else begin
            o_done    <= 1'b0;
            o_inst_we <= 1'b0;
            case (state)
                LD_IDLE: if (i_start) state <= LD_COUNT;
                LD_COUNT: if (i_rx_valid) begin
                    count    <= inst_addr_t'(i_rx_data);
                    inst_idx <= '0;
                    byte_idx <= '0;
                    if (i_rx_data == '0) begin
                        o_done <= 1'b1; // Empty program
                        state  <= LD_IDLE;
                    end else begin
                        state <= LD_DATA;
                    end
                end
                LD_DATA: if (i_rx_valid) begin
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == 2'd3) begin
                        o_inst_we    <= 1'b1;
                        o_write_addr <= inst_idx;
                        inst_idx     <= inst_idx + 1'b1;
                        if (inst_idx + 1'b1 == count) begin
                            o_done <= 1'b1;
                            state  <= LD_IDLE;
                        end
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == LD_DATA && i_rx_valid) begin
            if (byte_idx == 2'd3) begin
                o_write_data <= {i_rx_data, inst_buf}; // Little-endian
            end else begin
                inst_buf[8*byte_idx +: 8] <= i_rx_data;
            end
        end
    end

endmodule

//--- hw/dump_sender.sv
`timescale 1ns/1ps

module dump_sender (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_req,
    input  debug_pkg::dump_kind_t i_kind,
    input  debug_pkg::reg_bank_t  i_registers,
    input  debug_pkg::mem_word_t  i_mem_word,
    input  logic                  i_tx_done,
    output logic                  o_tx_start,
    output uart_pkg::uart_byte_t  o_tx_data,
    output logic                  o_done
);
    import debug_pkg::*;

    typedef enum logic [1:0] {DS_IDLE, DS_SEND, DS_WAIT} ds_state_t;

    ds_state_t  state;
    logic [7:0] bytes_left; // Data bytes before the acknowledge
    reg_bank_t  snap;

    // Low byte of the snapshot, or the acknowledge once the data is out
    assign o_tx_data = (bytes_left == '0) ? ACK_BYTE : snap[7:0];

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state      <= DS_IDLE;
            bytes_left <= '0;
            o_tx_start <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_tx_start <= (state == DS_SEND);
            o_done     <= 1'b0;
            case (state)
                DS_IDLE: if (i_req) begin
                    case (i_kind)
                        DUMP_REGS: bytes_left <= 8'(REG_BANK_BYTES);
                        DUMP_MEM:  bytes_left <= 8'd4;
                        default:   bytes_left <= '0;
                    endcase
                    state <= DS_SEND;
                end
                DS_SEND: state <= DS_WAIT;
                DS_WAIT: if (i_tx_done) begin
                    if (bytes_left == '0) begin
                        o_done <= 1'b1; // Acknowledge has left the line
                        state  <= DS_IDLE;
                    end else begin
                        bytes_left <= bytes_left - 1'b1;
                        state      <= DS_SEND;
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == DS_IDLE && i_req) begin
            snap <= (i_kind == DUMP_MEM) ? reg_bank_t'(i_mem_word) : i_registers;
        end else if (state == DS_WAIT && i_tx_done) begin
            snap <= snap >> 8;
        end
    end

endmodule

//--- hw/debug_unit.sv
`timescale 1ns/1ps

module debug_unit #(
    parameter int P_BAUD_DIV = uart_pkg::UART_DEFAULT_BAUD_DIV
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_uart_rx,
    input  debug_pkg::reg_bank_t   i_registers,
    input  debug_pkg::mem_word_t   i_debug_data,
    output logic                   o_uart_tx,
    output logic                   o_mode,
    output logic                   o_step_en,
    output debug_pkg::mem_addr_t   o_debug_addr,
    output logic                   o_inst_we,
    output debug_pkg::inst_addr_t  o_write_addr,
    output debug_pkg::inst_t       o_write_data
);
    import uart_pkg::*;
    import debug_pkg::*;

    logic       tick;
    logic       rx_valid;
    uart_byte_t rx_data;
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_done;
    logic       load_start;
    logic       load_done;
    logic       dump_req;
    dump_kind_t dump_kind;
    logic       dump_done;

    uart_baud_gen #(.P_BAUD_DIV(P_BAUD_DIV)) u_baud_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_uart_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_uart_rx),
        .o_valid (rx_valid),
        .o_data  (rx_data)
    );

    uart_tx u_uart_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_done  (tx_done),
        .o_tx    (o_uart_tx)
    );

    command_fsm u_command_fsm (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_valid   (rx_valid),
        .i_rx_data    (rx_data),
        .i_load_done  (load_done),
        .i_dump_done  (dump_done),
        .o_mode       (o_mode),
        .o_step_en    (o_step_en),
        .o_debug_addr (o_debug_addr),
        .o_load_start (load_start),
        .o_dump_req   (dump_req),
        .o_dump_kind  (dump_kind)
    );

    program_loader u_program_loader (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_start      (load_start),
        .i_rx_valid   (rx_valid),
        .i_rx_data    (rx_data),
        .o_done       (load_done),
        .o_inst_we    (o_inst_we),
        .o_write_addr (o_write_addr),
        .o_write_data (o_write_data)
    );

    dump_sender u_dump_sender (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req       (dump_req),
        .i_kind      (dump_kind),
        .i_registers (i_registers),
        .i_mem_word  (i_debug_data),
        .i_tx_done   (tx_done),
        .o_tx_start  (tx_start),
        .o_tx_data   (tx_data),
        .o_done      (dump_done)
    );

endmodule

//--- dv/debug_unit_sva.sv
`timescale 1ns/1ps

module debug_unit_sva (
    input logic i_clk,
    input logic i_reset,
    input logic o_uart_tx,
    input logic o_mode,
    input logic o_step_en,
    input logic o_inst_we
);

    // Write strobe is a single-cycle pulse
    inst_we_single: assert property (
        @(posedge i_clk) disable iff (i_reset) o_inst_we |=> !o_inst_we
    ) else $error("o_inst_we stayed high for two cycles");

    // Continuous mode keeps the pipeline enabled
    step_en_in_continuous: assert property (
        @(posedge i_clk) disable iff (i_reset) !o_mode |-> o_step_en
    ) else $error("o_step_en low while o_mode is continuous");

    tx_idle_in_reset: assert property (
        @(posedge i_clk) i_reset |-> o_uart_tx
    ) else $error("o_uart_tx not idle during reset");

endmodule

bind debug_unit debug_unit_sva u_debug_unit_sva (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .o_uart_tx (o_uart_tx),
    .o_mode    (o_mode),
    .o_step_en (o_step_en),
    .o_inst_we (o_inst_we)
);

//--- dv/tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit;
    import uart_pkg::*;
    import debug_pkg::*;

    localparam int          BAUD_DIV       = 2;
    localparam int          BIT_CYCLES     = BAUD_DIV * UART_TICKS_PER_BIT;
    localparam int          FRAME_CYCLES   = 10 * BIT_CYCLES;
    localparam int          RX_WAIT_CYCLES = 3 * FRAME_CYCLES;
    localparam int          RESET_CYCLES   = 16;
    localparam int          TOTAL_FRAMES   = 170; // Commands, replies and idle windows
    localparam int          TIMEOUT_CYCLES = 2 * TOTAL_FRAMES * FRAME_CYCLES + 4000;
    localparam int unsigned RAND_SEED      = 32'h8a72_3619;

    logic       i_clk     = 1'b0;
    logic       i_reset   = 1'b1;
    logic       i_uart_rx = 1'b1;
    reg_bank_t  registers = '0;
    mem_word_t  debug_data;
    logic       o_uart_tx;
    logic       o_mode;
    logic       o_step_en;
    mem_addr_t  o_debug_addr;
    logic       o_inst_we;
    inst_addr_t o_write_addr;
    inst_t      o_write_data;

    int         cycle_count = 0;
    inst_addr_t wr_addr[$];
    inst_t      wr_data[$];

    debug_unit #(.P_BAUD_DIV(BAUD_DIV)) i_dut (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_uart_rx    (i_uart_rx),
        .i_registers  (registers),
        .i_debug_data (debug_data),
        .o_uart_tx    (o_uart_tx),
        .o_mode       (o_mode),
        .o_step_en    (o_step_en),
        .o_debug_addr (o_debug_addr),
        .o_inst_we    (o_inst_we),
        .o_write_addr (o_write_addr),
        .o_write_data (o_write_data)
    );

    always #20 i_clk = ~i_clk;

    // Data memory model where every address bit shows up in the word
    function automatic mem_word_t model_word(input mem_addr_t a);
        return {a, 2'b10, ~a, 2'b01, a ^ 6'h2a, 2'b11, {2'b00, a} ^ 8'h5c};
    endfunction

    assign debug_data = model_word(o_debug_addr);

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
            abort_run();
        end
    end

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_inst(input inst_addr_t got_addr, input inst_t got_data,
                              input inst_addr_t exp_addr, input inst_t exp_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            $display("mismatch o_write_addr/o_write_data: got 0x%h/0x%h, expected 0x%h/0x%h",
                     got_addr, got_data, exp_addr, exp_data);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // Host side of the serial link drives inputs on the falling edge
    task automatic send_byte(input uart_byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0}; // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(negedge i_clk);
            i_uart_rx = frame[i];
            repeat (BIT_CYCLES - 1) @(negedge i_clk);
        end
    endtask

    task automatic receive_byte(output uart_byte_t data);
        int waited;
        waited = 0;
        data   = '0;
        while (o_uart_tx === 1'b1 && waited < RX_WAIT_CYCLES) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_uart_tx !== 1'b0) begin
            $display("no start bit on o_uart_tx within %0d cycles", RX_WAIT_CYCLES);
            abort_run();
        end else begin
            repeat (BIT_CYCLES / 2) @(negedge i_clk); // Middle of the start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge i_clk);
                data[i] = o_uart_tx;
            end
            repeat (BIT_CYCLES) @(negedge i_clk);
            if (o_uart_tx !== 1'b1) begin
                $display("stop bit on o_uart_tx is low");
                abort_run();
            end
        end
    endtask

    // Data bytes low byte first, then the acknowledge
    task automatic expect_reply(input int n_bytes, input reg_bank_t expected);
        uart_byte_t got;
        for (int k = 0; k < n_bytes; k++) begin
            receive_byte(got);
            check_byte($sformatf("o_uart_tx byte %0d", k), got, expected[8*k +: 8]);
        end
        receive_byte(got);
        check_byte("o_uart_tx acknowledge", got, ACK_BYTE);
    endtask

    task automatic expect_idle(input int cycles);
        logic seen_tx;
        seen_tx = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge i_clk);
            if (o_uart_tx !== 1'b1) seen_tx = 1'b1;
        end
        if (seen_tx) begin
            $display("o_uart_tx sent a frame where no reply was due");
            abort_run();
        end
    endtask

    task automatic watch_step_pulse();
        int waited;
        waited = 0;
        while (o_step_en !== 1'b1 && waited < 2 * FRAME_CYCLES) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_step_en !== 1'b1) begin
            $display("o_step_en did not pulse after the step command");
            abort_run();
        end else begin
            @(negedge i_clk);
            check_level("o_step_en", o_step_en, 1'b0); // One cycle only
        end
    endtask

    task automatic capture_writes(input int count);
        while (wr_addr.size() < count) begin
            @(negedge i_clk);
            if (o_inst_we) begin
                wr_addr.push_back(o_write_addr);
                wr_data.push_back(o_write_data);
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge i_clk);
        check_level("o_mode", o_mode, 1'b0);
        check_level("o_step_en", o_step_en, 1'b1);
        check_level("o_inst_we", o_inst_we, 1'b0);
        check_level("o_uart_tx", o_uart_tx, 1'b1);
    endtask

    task automatic test_modes();
        send_byte(CMD_STEP_MODE);
        check_level("o_mode", o_mode, 1'b1);
        check_level("o_step_en", o_step_en, 1'b0);
        expect_idle(FRAME_CYCLES);
        fork
            send_byte(CMD_STEP);
            watch_step_pulse();
        join
        check_level("o_step_en", o_step_en, 1'b0);
        expect_idle(FRAME_CYCLES);
        send_byte(CMD_CONTINUOUS);
        check_level("o_mode", o_mode, 1'b0);
        check_level("o_step_en", o_step_en, 1'b1);
        expect_idle(FRAME_CYCLES);
    endtask

    task automatic test_register_dump();
        @(negedge i_clk);
        for (int i = 0; i < NUM_REGISTERS; i++) begin
            registers[32*i +: 32] = $urandom();
        end
        fork
            send_byte(CMD_DUMP_REGS);
            expect_reply(REG_BANK_BYTES, registers);
        join
    endtask

    task automatic test_memory_read(input uart_byte_t addr_byte);
        fork
            begin
                send_byte(CMD_READ_MEM);
                send_byte(addr_byte);
            end
            expect_reply(4, reg_bank_t'(model_word(addr_byte[5:0])));
        join
        check_byte("o_debug_addr", uart_byte_t'(o_debug_addr), {2'b00, addr_byte[5:0]});
    endtask

    task automatic test_program_load();
        uart_byte_t prog[12];
        for (int i = 0; i < 12; i++) begin
            prog[i] = uart_byte_t'($urandom());
        end
        send_byte(CMD_STEP_MODE);
        check_level("o_mode", o_mode, 1'b1);
        fork
            begin
                send_byte(CMD_LOAD);
                check_level("o_mode", o_mode, 1'b0); // Forced continuous during load
                send_byte(8'd3);
                for (int i = 0; i < 12; i++) begin
                    send_byte(prog[i]);
                end
            end
            capture_writes(3);
        join
        for (int i = 0; i < 3; i++) begin
            check_inst(wr_addr[i], wr_data[i], inst_addr_t'(i),
                       {prog[4*i+3], prog[4*i+2], prog[4*i+1], prog[4*i]});
        end
        fork
            send_byte(CMD_RUN);
            expect_reply(0, '0);
        join
        check_level("o_mode", o_mode, 1'b1);
        check_level("o_step_en", o_step_en, 1'b0);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        test_reset_state();
        test_modes();
        test_register_dump();
        test_memory_read(8'hc5);
        test_memory_read(uart_byte_t'($urandom()));
        test_program_load();
        repeat (4) @(negedge i_clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- filelist.f
common/uart_pkg.sv
common/debug_pkg.sv
uart/uart_baud_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
hw/command_fsm.sv
hw/program_loader.sv
hw/dump_sender.sv
hw/debug_unit.sv
dv/debug_unit_sva.sv
dv/tb_debug_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the debug unit testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_debug_unit \
    -f filelist.f -o sim_debug_unit &&
./obj_dir/sim_debug_unit ||
exit 1
